/* rtl/pdp8_pkg.sv */
// PDP-8 core shared types
// Word types, control encodings and bus structs

package pdp8_pkg;

  localparam int WORD_WIDTH  = 12;     // Machine word
  localparam int MEM_WORDS   = 4096;   // Full 4K field
  localparam int MEM_LATENCY = 2;      // Enabled cycle that finishes an access

  typedef logic [WORD_WIDTH-1:0] word_t;
  typedef logic [WORD_WIDTH-1:0] addr_t;

  localparam word_t HALT_WORD = 12'o7402;

  typedef enum logic [2:0] {
    OP_AND, OP_TAD, OP_ISZ, OP_DCA, OP_JMS, OP_JMP, OP_IOT, OP_OPR
  } opcode_t;

  typedef enum logic [4:0] {
    S_REG_INIT, S_IDLE, S_LD_PC, S_LD_AC,
    S_DEP_1, S_DEP_2, S_EXAM_1, S_EXAM_2,
    S_FETCH_1, S_FETCH_2, S_FETCH_3,
    S_EA_CALC, S_EA_IND_1, S_EA_IND_2, S_EA_IND_3,
    S_DECODE, S_RD_1, S_RD_2, S_AND, S_TAD,
    S_ISZ_INC, S_ISZ_WR_1, S_ISZ_WR_2, S_ISZ_SKIP,
    S_DCA_1, S_DCA_2, S_DCA_3,
    S_JMS_1, S_JMS_2, S_JMS_3,
    S_HALT
  } ctrl_state_t;

  typedef enum logic [2:0] {AC_HOLD, AC_CLEAR, AC_SWITCH, AC_AND, AC_TAD} ac_op_t;
  typedef enum logic [2:0] {PC_HOLD, PC_SWITCH, PC_PLUS1, PC_PLUS2, PC_JUMP} pc_op_t;
  typedef enum logic [1:0] {EA_HOLD, EA_PAGE_ZERO, EA_CURR_PAGE, EA_INDIRECT} ea_op_t;
  typedef enum logic [1:0] {MB_READ, MB_INC, MB_HOLD} mb_op_t;
  typedef enum logic [1:0] {AD_PC, AD_EA, AD_SWITCH} ad_sel_t;
  typedef enum logic [1:0] {WD_AC, WD_MB, WD_PC_PLUS1, WD_SWITCH} wd_sel_t;

  typedef struct packed {
    ac_op_t  ac_op;
    pc_op_t  pc_op;
    ea_op_t  ea_op;
    mb_op_t  mb_op;
    ad_sel_t ad_sel;
    wd_sel_t wd_sel;
    logic    ir_load;
    logic    link_clear;
  } dp_ctrl_t;

  typedef struct packed {
    word_t ir;
    word_t mb;
  } dp_status_t;

  typedef struct packed {
    logic  read_enable;
    logic  write_enable;
    addr_t address;
    word_t write_data;
  } mem_req_t;

  typedef struct packed {
    word_t ac;
    word_t pc;
    word_t mb;
    logic  link;
    logic  idle;
  } panel_status_t;

endpackage

/* rtl/core_memory.sv */
// 4K word core memory

`timescale 1ns/100ps

module core_memory import pdp8_pkg::*; (
  input  logic     clock,
  input  logic     resetN,
  input  mem_req_t request,
  output word_t    read_data,
  output logic     mem_finished
);

  localparam int CNT_W = $clog2(MEM_LATENCY + 1);

  word_t            mem [MEM_WORDS];
  logic [CNT_W-1:0] count;
  logic             active;

  assign active       = request.read_enable || request.write_enable;
  assign mem_finished = active && (count == CNT_W'(MEM_LATENCY - 1));

  // Counts enabled cycles of the current access
  always_ff @(posedge clock, negedge resetN) begin
    if (!resetN)
      count <= '0;
    else if (!active || mem_finished)
      count <= '0;
    else
      count <= count + 1'b1;
  end

  always_ff @(posedge clock) begin
    if (request.write_enable && mem_finished)
      mem[request.address] <= request.write_data;
    read_data <= mem[request.address];   // Valid by the finishing cycle
  end

endmodule

/* rtl/pdp8_datapath.sv */
// PDP-8 register and arithmetic datapath

`timescale 1ns/100ps

module pdp8_datapath import pdp8_pkg::*; (
  input  logic       clock,
  input  logic       resetN,
  input  dp_ctrl_t   ctrl,
  input  word_t      switch_reg,
  input  word_t      read_data,
  input  logic       mem_finished,
  output dp_status_t status,
  output word_t      ac,
  output logic       link,
  output word_t      pc,
  output addr_t      address,
  output word_t      write_data
);

  word_t               ir;
  word_t               mb;
  addr_t               ea;
  word_t               pc_plus1;
  logic [WORD_WIDTH:0] tad_sum;

  assign pc_plus1 = pc + word_t'(1);
  assign tad_sum  = {1'b0, ac} + {1'b0, mb};   // Carry out lands in the top bit
  assign status   = '{ir: ir, mb: mb};

  // Accumulator and link
  always_ff @(posedge clock, negedge resetN) begin
    if (!resetN) begin
      ac   <= '0;
      link <= 1'b0;
    end else begin
      case (ctrl.ac_op)
        AC_CLEAR:  ac <= '0;
        AC_SWITCH: ac <= switch_reg;
        AC_AND:    ac <= ac & mb;
        AC_TAD: begin
          ac   <= tad_sum[WORD_WIDTH-1:0];
          link <= link ^ tad_sum[WORD_WIDTH];   // Carry complements link
        end
        default: ;
      endcase
      if (ctrl.link_clear)
        link <= 1'b0;
    end
  end

  // Program counter
  always_ff @(posedge clock, negedge resetN) begin
    if (!resetN)
      pc <= '0;
    else case (ctrl.pc_op)
      PC_SWITCH: pc <= switch_reg;
      PC_PLUS1:  pc <= pc_plus1;
      PC_PLUS2:  pc <= pc + word_t'(2);
      PC_JUMP:   pc <= ea;
      default: ;
    endcase
  end

  // Instruction, effective address and memory buffer
  always_ff @(posedge clock, negedge resetN) begin
    if (!resetN) begin
      ir <= '0;
      ea <= '0;
      mb <= '0;
    end else begin
      if (ctrl.ir_load)
        ir <= mb;
      case (ctrl.ea_op)
        EA_PAGE_ZERO: ea <= {5'b0, ir[6:0]};
        EA_CURR_PAGE: ea <= {pc[11:7], ir[6:0]};
        EA_INDIRECT:  ea <= mb;                 // Pointer word just read
        default: ;
      endcase
      if (ctrl.mb_op == MB_READ && mem_finished)
        mb <= read_data;
      else if (ctrl.mb_op == MB_INC)
        mb <= mb + word_t'(1);                  // Wraps 7777 to 0000
    end
  end

  // Memory address and write data
  always_ff @(posedge clock) begin
    case (ctrl.ad_sel)
      AD_EA:     address <= ea;
      AD_SWITCH: address <= switch_reg;
      default:   address <= pc;
    endcase
    case (ctrl.wd_sel)
      WD_MB:       write_data <= mb;
      WD_PC_PLUS1: write_data <= pc_plus1;     // JMS return address
      WD_SWITCH:   write_data <= switch_reg;
      default:     write_data <= ac;
    endcase
  end

endmodule

/* rtl/pdp8_control.sv */
// PDP-8 instruction and panel sequencer

`timescale 1ns/100ps

module pdp8_control import pdp8_pkg::*; (
  input  logic       clock,
  input  logic       resetN,
  input  logic       run,
  input  logic       step,
  input  logic       load_pc,
  input  logic       load_ac,
  input  logic       deposit,
  input  logic       examine,
  input  dp_status_t status,
  input  logic       mem_finished,
  output dp_ctrl_t   ctrl,
  output logic       read_enable,
  output logic       write_enable,
  output logic       idle,
  output logic       halt
);

  ctrl_state_t state;
  ctrl_state_t next_state;
  logic        run_flag;
  opcode_t     opcode;

  assign opcode       = opcode_t'(status.ir[11:9]);
  assign idle         = (state == S_IDLE) && !run_flag;   // Panel accepts commands
  assign halt         = (state == S_HALT);
  assign read_enable  = state inside {S_EXAM_2, S_FETCH_2, S_EA_IND_2, S_RD_2};
  assign write_enable = state inside {S_DEP_2, S_ISZ_WR_2, S_DCA_2, S_JMS_2};

  always_ff @(posedge clock, negedge resetN) begin
    if (!resetN) begin
      state    <= S_REG_INIT;
      run_flag <= 1'b0;
    end else begin
      state <= next_state;
      if (state == S_HALT)
        run_flag <= 1'b0;                 // HALT ends the run
      else if (idle && run)
        run_flag <= 1'b1;
    end
  end

  always_comb begin
    next_state = state;                   // Wait states hold by default
    case (state)
      S_REG_INIT: next_state = S_IDLE;
      S_IDLE: begin
        if (run_flag || run || step) next_state = S_FETCH_1;
        else if (examine)            next_state = S_EXAM_1;
        else if (load_pc)            next_state = S_LD_PC;
        else if (load_ac)            next_state = S_LD_AC;
        else if (deposit)            next_state = S_DEP_1;
      end
      S_LD_PC, S_LD_AC:    next_state = S_IDLE;
      S_DEP_1:             next_state = S_DEP_2;
      S_DEP_2:             if (mem_finished) next_state = S_IDLE;
      S_EXAM_1:            next_state = S_EXAM_2;
      S_EXAM_2:            if (mem_finished) next_state = S_IDLE;
      S_FETCH_1:           next_state = S_FETCH_2;
      S_FETCH_2:           if (mem_finished) next_state = S_FETCH_3;
      S_FETCH_3:           next_state = S_EA_CALC;
      S_EA_CALC:           next_state = status.ir[8] ? S_EA_IND_1 : S_DECODE;
      S_EA_IND_1:          next_state = S_EA_IND_2;
      S_EA_IND_2:          if (mem_finished) next_state = S_EA_IND_3;
      S_EA_IND_3:          next_state = S_DECODE;
      S_DECODE: begin
        if (status.ir == HALT_WORD) next_state = S_HALT;
        else case (opcode)
          OP_AND, OP_TAD, OP_ISZ: next_state = S_RD_1;
          OP_DCA:                 next_state = S_DCA_1;
          OP_JMS:                 next_state = S_JMS_1;
          default:                next_state = S_IDLE;   // JMP, IOT, OPR finish here
        endcase
      end
      S_RD_1:              next_state = S_RD_2;
      S_RD_2: begin
        if (mem_finished)
          next_state = (opcode == OP_AND) ? S_AND :
                       (opcode == OP_TAD) ? S_TAD : S_ISZ_INC;
      end
      S_ISZ_INC:           next_state = S_ISZ_WR_1;
      S_ISZ_WR_1:          next_state = S_ISZ_WR_2;
      S_ISZ_WR_2:          if (mem_finished) next_state = S_ISZ_SKIP;
      S_DCA_1:             next_state = S_DCA_2;
      S_DCA_2:             if (mem_finished) next_state = S_DCA_3;
      S_JMS_1:             next_state = S_JMS_2;
      S_JMS_2:             if (mem_finished) next_state = S_JMS_3;
      default:             next_state = S_IDLE;
    endcase
  end

  // Address and write data selects stay put through each wait state
  always_comb begin
    ctrl.ac_op      = AC_HOLD;
    ctrl.pc_op      = PC_HOLD;
    ctrl.ea_op      = EA_HOLD;
    ctrl.mb_op      = read_enable ? MB_READ : MB_HOLD;
    ctrl.ad_sel     = AD_PC;
    ctrl.wd_sel     = WD_AC;
    ctrl.ir_load    = 1'b0;
    ctrl.link_clear = 1'b0;
    if (state inside {S_EA_IND_1, S_EA_IND_2, S_RD_1, S_RD_2, S_ISZ_WR_1, S_ISZ_WR_2,
                      S_DCA_1, S_DCA_2, S_JMS_1, S_JMS_2})
      ctrl.ad_sel = AD_EA;
    case (state)
      S_REG_INIT: begin
        ctrl.ac_op      = AC_CLEAR;
        ctrl.link_clear = 1'b1;
      end
      S_LD_PC:                ctrl.pc_op  = PC_SWITCH;
      S_LD_AC:                ctrl.ac_op  = AC_SWITCH;
      S_DEP_1:                ctrl.wd_sel = WD_SWITCH;
      S_DEP_2: begin
        ctrl.wd_sel = WD_SWITCH;
        if (mem_finished) ctrl.pc_op = PC_PLUS1;
      end
      S_EXAM_1, S_EXAM_2:     ctrl.ad_sel  = AD_SWITCH;
      S_FETCH_3:              ctrl.ir_load = 1'b1;
      S_EA_CALC:              ctrl.ea_op = status.ir[7] ? EA_CURR_PAGE : EA_PAGE_ZERO;
      S_EA_IND_3:             ctrl.ea_op = EA_INDIRECT;
      S_DECODE: begin
        case (opcode)
          OP_JMP:         ctrl.pc_op = PC_JUMP;
          OP_IOT, OP_OPR: ctrl.pc_op = PC_PLUS1;   // HALT word included
          default:        ctrl.pc_op = PC_HOLD;
        endcase
      end
      S_AND: begin
        ctrl.ac_op = AC_AND;
        ctrl.pc_op = PC_PLUS1;
      end
      S_TAD: begin
        ctrl.ac_op = AC_TAD;
        ctrl.pc_op = PC_PLUS1;
      end
      S_ISZ_INC:              ctrl.mb_op  = MB_INC;
      S_ISZ_WR_1, S_ISZ_WR_2: ctrl.wd_sel = WD_MB;
      S_ISZ_SKIP:             ctrl.pc_op  = (status.mb == '0) ? PC_PLUS2 : PC_PLUS1;
      S_DCA_3: begin
        ctrl.ac_op = AC_CLEAR;
        ctrl.pc_op = PC_PLUS1;
      end
      S_JMS_1:                ctrl.wd_sel = WD_PC_PLUS1;
      S_JMS_2: begin
        ctrl.wd_sel = WD_PC_PLUS1;
        if (mem_finished) ctrl.pc_op = PC_JUMP;   // PC moves only once the write is done
      end
      S_JMS_3:                ctrl.pc_op  = PC_PLUS1;
      default: ;
    endcase
  end

endmodule

/* rtl/pdp8_top.sv */
// PDP-8 processor top level

`timescale 1ns/100ps

module pdp8_top import pdp8_pkg::*; (
  input  logic          clock,
  input  logic          resetN,
  input  word_t         switch_reg,
  input  logic          run,
  input  logic          step,
  input  logic          load_pc,
  input  logic          load_ac,
  input  logic          deposit,
  input  logic          examine,
  output panel_status_t panel,
  output logic          halt
);

  dp_ctrl_t   ctrl;
  dp_status_t status;
  mem_req_t   request;
  logic       read_enable;
  logic       write_enable;
  logic       mem_finished;
  logic       idle;
  logic       link;
  word_t      ac;
  word_t      pc;
  word_t      read_data;
  word_t      write_data;
  addr_t      address;

  assign request = '{read_enable: read_enable, write_enable: write_enable,
                     address: address, write_data: write_data};
  assign panel   = '{ac: ac, pc: pc, mb: status.mb, link: link, idle: idle};

  pdp8_control u_control (
    .clock, .resetN, .run, .step, .load_pc, .load_ac, .deposit, .examine,
    .status, .mem_finished, .ctrl, .read_enable, .write_enable, .idle, .halt
  );

  pdp8_datapath u_datapath (
    .clock, .resetN, .ctrl, .switch_reg, .read_data, .mem_finished,
    .status, .ac, .link, .pc, .address, .write_data
  );

  core_memory u_memory (
    .clock, .resetN, .request, .read_data, .mem_finished
  );

endmodule

/* dv/pdp8_control_sva.sv */
// Sequencer protocol assertions

`timescale 1ns/100ps

module pdp8_control_sva (
  input logic clock,
  input logic resetN,
  input logic read_enable,
  input logic write_enable,
  input logic mem_finished,
  input logic idle,
  input logic halt
);

  enables_exclusive: assert property (@(posedge clock) disable iff (!resetN)
    !(read_enable && write_enable))
    else $error("read_enable and write_enable high together");

  halt_one_cycle: assert property (@(posedge clock) disable iff (!resetN)
    halt |=> !halt)
    else $error("halt held longer than one cycle");

  // Enables wait for the memory to finish
  read_held: assert property (@(posedge clock) disable iff (!resetN)
    read_enable && !mem_finished |=> read_enable)
    else $error("read_enable dropped before mem_finished");

  write_held: assert property (@(posedge clock) disable iff (!resetN)
    write_enable && !mem_finished |=> write_enable)
    else $error("write_enable dropped before mem_finished");

  idle_after_reset: assert property (@(posedge clock) $rose(resetN) |=> idle)
    else $error("idle not reached after reset");

endmodule

bind pdp8_control pdp8_control_sva u_control_sva (
  .clock, .resetN, .read_enable, .write_enable, .mem_finished, .idle, .halt
);

/* dv/pdp8_tb.sv */
// PDP-8 processor testbench

`timescale 1ns/100ps

module pdp8_tb import pdp8_pkg::*; ();

  localparam int          RESET_CYCLES = 10;
  localparam int          IDLE_LIMIT   = 200;
  localparam int          RUN_LIMIT    = 20000;
  localparam int          PROGRAMS     = 6;
  localparam logic [31:0] LFSR_TAPS    = 32'h8020_0003;

  typedef enum {CMD_RUN, CMD_STEP, CMD_LOAD_PC, CMD_LOAD_AC, CMD_DEPOSIT, CMD_EXAMINE} command_t;

  logic          clock;
  logic          resetN;
  word_t         switch_reg;
  logic          run;
  logic          step;
  logic          load_pc;
  logic          load_ac;
  logic          deposit;
  logic          examine;
  panel_status_t panel;
  logic          halt;

  logic [31:0]   lfsr = 32'h97a4_2084;
  int            halt_count;
  word_t         model_mem [MEM_WORDS];   // Instruction-level reference state
  word_t         model_ac;
  word_t         model_pc;
  logic          model_link;

  pdp8_top UUT (
    .clock, .resetN, .switch_reg, .run, .step, .load_pc, .load_ac, .deposit, .examine,
    .panel, .halt
  );

  initial begin
    clock = 1'b0;
    forever #20 clock = ~clock;
  end

  always @(posedge clock, negedge resetN) begin
    if (!resetN)
      halt_count <= 0;
    else if (halt)
      halt_count <= halt_count + 1;
  end

  // Galois LFSR stepped once for each bit taken
  function automatic word_t random_bits(input int count);
    word_t value;
    value = '0;
    for (int i = 0; i < count; i++) begin
      value = {value[WORD_WIDTH-2:0], lfsr[0]};
      lfsr  = (lfsr >> 1) ^ (lfsr[0] ? LFSR_TAPS : 32'h0);
    end
    return value;
  endfunction

  task automatic stop_on_failure();
    $display("Simulation failed");
    $fatal(1);
  endtask

  task automatic check_word(input string name, input word_t expected, input word_t actual);
    if (actual !== expected) begin
      $display("FAILED at %0t: %s expected %o, actual %o", $time, name, expected, actual);
      stop_on_failure();
    end
  endtask

  task automatic check_bit(input string name, input logic expected, input logic actual);
    if (actual !== expected) begin
      $display("FAILED at %0t: %s expected %b, actual %b", $time, name, expected, actual);
      stop_on_failure();
    end
  endtask

  task automatic check_panel(input string name, input panel_status_t expected,
                             input panel_status_t actual);
    if (actual !== expected) begin
      $display("FAILED at %0t: %s expected %h, actual %h", $time, name, expected, actual);
      stop_on_failure();
    end
  endtask

  task automatic wait_idle(input string after);
    int cycles;
    cycles = 0;
    do begin
      @(posedge clock);
      cycles++;
      if (cycles > IDLE_LIMIT) begin
        $display("Timeout: panel never returned to idle after %s", after);
        stop_on_failure();
      end
    end while (!panel.idle);
  endtask

  task automatic wait_halt();
    int cycles;
    cycles = 0;
    do begin
      @(posedge clock);
      cycles++;
      if (cycles > RUN_LIMIT) begin
        $display("Timeout: the running program never raised halt");
        stop_on_failure();
      end
    end while (!halt);
  endtask

  // One-cycle command pulse with the switch register set alongside
  task automatic drive_command(input command_t command, input word_t value);
    @(posedge clock);
    switch_reg <= value;
    case (command)
      CMD_RUN:     run     <= 1'b1;
      CMD_STEP:    step    <= 1'b1;
      CMD_LOAD_PC: load_pc <= 1'b1;
      CMD_LOAD_AC: load_ac <= 1'b1;
      CMD_DEPOSIT: deposit <= 1'b1;
      CMD_EXAMINE: examine <= 1'b1;
      default: ;
    endcase
    @(posedge clock);
    {run, step, load_pc, load_ac, deposit, examine} <= '0;
  endtask

  task automatic panel_op(input command_t command, input word_t value, input string name);
    drive_command(command, value);
    wait_idle(name);
  endtask

  function automatic addr_t data_address();
    if (random_bits(1) != 0)
      return addr_t'(64) + random_bits(6);    // Page zero data 0100-0177
    return addr_t'(208) + random_bits(5);     // Page one data 0320-0357
  endfunction

  function automatic word_t data_reference(input int opcode);
    logic       indirect;
    logic       current;
    logic [6:0] offset;
    indirect = random_bits(1) != 0;
    current  = random_bits(1) != 0;
    if (indirect && current)
      offset = 7'(64 + random_bits(4));       // Pointers at 0300-0317
    else if (indirect)
      offset = 7'(random_bits(5));            // Pointers at 0000-0037
    else if (current)
      offset = 7'(80 + random_bits(5));
    else
      offset = 7'(64 + random_bits(6));
    return {opcode[2:0], indirect, current, offset};
  endfunction

  // Program at 0200 with a JMS subroutine at 0360 and pointers aimed only at data
  task automatic build_program();
    int    length;
    int    kind;
    addr_t addr;
    addr_t target;
    for (int a = 0; a < 256; a++) begin
      if (random_bits(2) == 0)
        model_mem[addr_t'(a)] = 12'o7774 | random_bits(2);   // Counters near 7777
      else
        model_mem[addr_t'(a)] = random_bits(12);
    end
    for (int a = 0; a < 32; a++)
      model_mem[addr_t'(a)] = data_address();
    for (int a = 192; a < 208; a++)
      model_mem[addr_t'(a)] = data_address();
    length = 16 + int'(random_bits(5));
    for (int i = 0; i < length; i++) begin
      addr = addr_t'(128 + i);
      kind = int'(random_bits(3));
      case (kind)
        0, 1, 2, 3: model_mem[addr] = data_reference(kind);
        4:          model_mem[addr] = 12'o4360;
        5: begin
          target = addr + addr_t'(1) + random_bits(2);   // Forward jumps only
          if (target > addr_t'(128 + length))
            target = addr_t'(128 + length);
          model_mem[addr] = {3'o5, 2'b01, target[6:0]};
        end
        6:          model_mem[addr] = 12'o6000 | random_bits(9);
        default:    model_mem[addr] = 12'o7000 | random_bits(8);
      endcase
    end
    model_mem[addr_t'(128 + length)] = HALT_WORD;
    model_mem[addr_t'(129 + length)] = HALT_WORD;   // Landing spot for a final skip
    model_mem[12'o361] = 12'o1100 | random_bits(6);
    model_mem[12'o362] = 12'o5760;                   // JMP I 0360
  endtask

  task automatic load_memory();
    panel_op(CMD_LOAD_PC, '0, "load_pc");
    for (int a = 0; a < 256; a++) begin
      panel_op(CMD_DEPOSIT, model_mem[addr_t'(a)], "deposit");
      check_word("panel.pc", word_t'(a + 1), panel.pc);
    end
    model_pc = word_t'(256);
  endtask

  task automatic verify_memory();
    panel_status_t expected;
    for (int a = 0; a < 256; a++) begin
      panel_op(CMD_EXAMINE, word_t'(a), "examine");
      expected = '{ac: model_ac, pc: model_pc, mb: model_mem[addr_t'(a)],
                   link: model_link, idle: 1'b1};
      check_panel("panel", expected, panel);
    end
  endtask

  task automatic model_step(output logic halted);
    word_t               inst;
    addr_t               ea;
    logic [WORD_WIDTH:0] sum;
    inst   = model_mem[model_pc];
    halted = (inst == HALT_WORD);
    ea     = inst[7] ? {model_pc[11:7], inst[6:0]} : {5'b0, inst[6:0]};
    if (inst[8])
      ea = model_mem[ea];
    case (inst[11:9])
      3'o0: begin
        model_ac = model_ac & model_mem[ea];
        model_pc = model_pc + word_t'(1);
      end
      3'o1: begin
        sum        = {1'b0, model_ac} + {1'b0, model_mem[ea]};
        model_ac   = sum[WORD_WIDTH-1:0];
        model_link = model_link ^ sum[WORD_WIDTH];
        model_pc   = model_pc + word_t'(1);
      end
      3'o2: begin
        model_mem[ea] = model_mem[ea] + word_t'(1);
        model_pc      = model_pc + ((model_mem[ea] == '0) ? word_t'(2) : word_t'(1));
      end
      3'o3: begin
        model_mem[ea] = model_ac;
        model_ac      = '0;
        model_pc      = model_pc + word_t'(1);
      end
      3'o4: begin
        model_mem[ea] = model_pc + word_t'(1);   // Return address at EA
        model_pc      = ea + word_t'(1);
      end
      3'o5:    model_pc = ea;
      default: model_pc = model_pc + word_t'(1);
    endcase
  endtask

  task automatic execute_program(input logic single_step);
    int   halts;
    logic halted;
    halted = 1'b0;
    halts  = halt_count;
    if (single_step) begin
      for (int i = 0; i < 1000 && !halted; i++) begin
        halts = halt_count;
        drive_command(CMD_STEP, model_pc);
        wait_idle("step");
        model_step(halted);
        check_word("panel.pc", model_pc, panel.pc);
        check_word("panel.ac", model_ac, panel.ac);
        check_bit("panel.link", model_link, panel.link);
        check_bit("halt seen", halted, halt_count != halts);
      end
    end else begin
      drive_command(CMD_RUN, model_pc);
      wait_halt();
      wait_idle("halt");
      for (int i = 0; i < 1000 && !halted; i++)
        model_step(halted);
      check_bit("single halt pulse", 1'b1, halt_count == halts + 1);
    end
    check_word("panel.ac", model_ac, panel.ac);
    check_word("panel.pc", model_pc, panel.pc);
    check_bit("panel.link", model_link, panel.link);
    verify_memory();
  endtask

  initial begin
    word_t         value;
    panel_status_t expected;
    resetN     <= 1'b0;
    switch_reg <= '0;
    {run, step, load_pc, load_ac, deposit, examine} <= '0;
    model_ac   = '0;
    model_pc   = '0;
    model_link = 1'b0;
    repeat (RESET_CYCLES) @(posedge clock);
    resetN <= 1'b1;
    wait_idle("reset");
    expected      = '{default: '0};
    expected.idle = 1'b1;
    check_panel("panel", expected, panel);
    check_bit("halt", 1'b0, halt);
    value = random_bits(12);
    panel_op(CMD_LOAD_PC, value, "load_pc");
    check_word("panel.pc", value, panel.pc);
    value = random_bits(12);
    panel_op(CMD_LOAD_AC, value, "load_ac");
    check_word("panel.ac", value, panel.ac);
    model_ac = value;
    for (int p = 0; p < PROGRAMS; p++) begin
      build_program();
      load_memory();
      verify_memory();
      panel_op(CMD_LOAD_PC, 12'o200, "load_pc");
      model_pc = 12'o200;
      execute_program(p % 2 == 1);    // Alternate run and single step
    end
    $display("Simulation passed");
    $finish;
  end

endmodule

/* pdp8_top.f */
rtl/pdp8_pkg.sv
rtl/core_memory.sv
rtl/pdp8_datapath.sv
rtl/pdp8_control.sv
rtl/pdp8_top.sv
dv/pdp8_control_sva.sv
dv/pdp8_tb.sv

/* run_sim.sh */
#!/bin/sh
# Compile and run the PDP-8 testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/100ps \
  --top-module pdp8_tb -f pdp8_top.f
if [ $? -ne 0 ]; then
  echo "Verilator compile failed"
  exit 1
fi

output=$(./obj_dir/Vpdp8_tb)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
  echo "Simulation run exited with status $status"
  exit 1
fi

if printf '%s\n' "$output" | grep -qx "Simulation passed"; then
  exit 0
fi
echo "Pass message not found in simulation output"
exit 1
